//--- source/haar_defines.svh
`ifndef HAAR_DEFINES_SVH
`define HAAR_DEFINES_SVH

// classifiers evaluated in one stage
`define HAAR_NUM_CLASSIFIERS 4

// parameter words per classifier
`define HAAR_NUM_SLOTS 18

// load and window data words
`define HAAR_WORD_W 16

// corner index into the window
`define HAAR_INDEX_W 8

// integral-image points per window
`define HAAR_WINDOW_DEPTH 256

`define HAAR_FEATURE_W 32
`define HAAR_STAGE_W 20

`endif

//--- source/haar_pkg.sv
`default_nettype none

`include "haar_defines.svh"

package haar_pkg;

	// one parameter word, read as a corner index or as a signed value
	typedef union packed {
		struct packed {
			logic [`HAAR_WORD_W-`HAAR_INDEX_W-1:0] pad;
			logic [`HAAR_INDEX_W-1:0] index;
		} idx;
		logic signed [`HAAR_WORD_W-1:0] value;
	} haar_word_u;

	// slot order within one classifier
	typedef enum logic [4:0] {
		slot_rect1_a    = 5'd0,
		slot_rect1_b    = 5'd1,
		slot_rect1_c    = 5'd2,
		slot_rect1_d    = 5'd3,
		slot_weight1    = 5'd4,
		slot_rect2_a    = 5'd5,
		slot_rect2_b    = 5'd6,
		slot_rect2_c    = 5'd7,
		slot_rect2_d    = 5'd8,
		slot_weight2    = 5'd9,
		slot_rect3_a    = 5'd10,
		slot_rect3_b    = 5'd11,
		slot_rect3_c    = 5'd12,
		slot_rect3_d    = 5'd13,
		slot_weight3    = 5'd14,
		slot_threshold  = 5'd15,
		slot_left       = 5'd16,
		slot_right      = 5'd17
	} haar_slot_e;

endpackage

`default_nettype wire

//--- source/haar_param_loader.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module haar_param_loader (
	input wire clk_fpga,
	input wire arst_n,
	input wire load_en,
	input wire [7:0] load_classifier,
	input wire [7:0] load_slot,
	input wire haar_pkg::haar_word_u load_data,
	output haar_pkg::haar_word_u [`HAAR_NUM_CLASSIFIERS*`HAAR_NUM_SLOTS-1:0] param_bank,
	output haar_pkg::haar_word_u stage_threshold
);

	localparam int BANK_DEPTH = `HAAR_NUM_CLASSIFIERS * `HAAR_NUM_SLOTS;
	localparam int BANK_AW = $clog2(BANK_DEPTH);

	logic [BANK_AW-1:0] bank_idx;
	logic slot_in_range;
	logic cls_in_range;
	logic thr_select;

	// flat position of classifier and slot in the bank
	always_comb
	begin
		bank_idx = BANK_AW'(load_classifier * `HAAR_NUM_SLOTS + load_slot);
	end

	assign slot_in_range = (load_slot <= 8'(haar_pkg::slot_right));
	assign cls_in_range = (load_classifier < 8'(`HAAR_NUM_CLASSIFIERS));

	// stage threshold sits one past the last classifier, slot zero
	assign thr_select = (load_classifier == 8'(`HAAR_NUM_CLASSIFIERS)) &&
		(load_slot == 8'(haar_pkg::slot_rect1_a));

	always_ff @(posedge clk_fpga or negedge arst_n)
	begin
		if (!arst_n)
		begin
			param_bank <= '0;
		end
		else if (load_en && cls_in_range && slot_in_range)
		begin
			param_bank[bank_idx] <= load_data;
		end
	end

	always_ff @(posedge clk_fpga or negedge arst_n)
	begin
		if (!arst_n)
		begin
			stage_threshold <= '0;
		end
		else if (load_en && thr_select)
		begin
			stage_threshold <= load_data;
		end
	end

endmodule

`default_nettype wire

//--- source/integral_window_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module integral_window_buffer (
	input wire clk_fpga,
	input wire win_we,
	input wire [`HAAR_INDEX_W-1:0] win_addr,
	input wire [`HAAR_WORD_W-1:0] win_data,
	input wire [`HAAR_INDEX_W-1:0] corner_addr_a,
	input wire [`HAAR_INDEX_W-1:0] corner_addr_b,
	input wire [`HAAR_INDEX_W-1:0] corner_addr_c,
	input wire [`HAAR_INDEX_W-1:0] corner_addr_d,
	output logic [`HAAR_WORD_W-1:0] corner_a,
	output logic [`HAAR_WORD_W-1:0] corner_b,
	output logic [`HAAR_WORD_W-1:0] corner_c,
	output logic [`HAAR_WORD_W-1:0] corner_d
);

	logic [`HAAR_WORD_W-1:0] window_mem [0:`HAAR_WINDOW_DEPTH-1];

	always_ff @(posedge clk_fpga)
	begin
		if (win_we)
		begin
			window_mem[win_addr] <= win_data;
		end
	end

	// four independent corner reads
	assign corner_a = window_mem[corner_addr_a];
	assign corner_b = window_mem[corner_addr_b];
	assign corner_c = window_mem[corner_addr_c];
	assign corner_d = window_mem[corner_addr_d];

endmodule

`default_nettype wire

//--- source/haar_feature_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module haar_feature_mac (
	input wire clk_fpga,
	input wire arst_n,
	input wire rect_valid,
	input wire rect_first,
	input wire rect_last,
	input wire [`HAAR_WORD_W-1:0] corner_a,
	input wire [`HAAR_WORD_W-1:0] corner_b,
	input wire [`HAAR_WORD_W-1:0] corner_c,
	input wire [`HAAR_WORD_W-1:0] corner_d,
	input wire haar_pkg::haar_word_u weight,
	input wire haar_pkg::haar_word_u threshold,
	input wire haar_pkg::haar_word_u left_vote,
	input wire haar_pkg::haar_word_u right_vote,
	output logic vote_valid,
	output logic signed [`HAAR_WORD_W-1:0] vote
);

	localparam int FW = `HAAR_FEATURE_W;

	logic signed [FW-1:0] rect_diff;
	logic signed [FW-1:0] weight_ext;
	logic signed [FW-1:0] threshold_ext;
	logic signed [FW-1:0] rect_term;
	logic signed [FW-1:0] feature_acc;
	logic signed [FW-1:0] feature_sum;

	// corner sum A - B - C + D, wraps like the accumulator
	assign rect_diff = FW'(corner_a) - FW'(corner_b) - FW'(corner_c) + FW'(corner_d);
	assign weight_ext = FW'(weight.value);
	assign threshold_ext = FW'(threshold.value);
	assign rect_term = rect_diff * weight_ext;

	// first rectangle drops the previous classifier's feature
	assign feature_sum = (rect_first ? '0 : feature_acc) + rect_term;

	always_ff @(posedge clk_fpga or negedge arst_n)
	begin
		if (!arst_n)
		begin
			feature_acc <= '0;
			vote_valid <= 1'b0;
		end
		else
		begin
			vote_valid <= rect_valid && rect_last;
			if (rect_valid)
			begin
				feature_acc <= feature_sum;
			end
		end
	end

	// equality falls through to the right vote
	always_ff @(posedge clk_fpga)
	begin
		if (rect_valid && rect_last)
		begin
			vote <= (feature_sum < threshold_ext) ? left_vote.value : right_vote.value;
		end
	end

endmodule

`default_nettype wire

//--- source/haar_stage_evaluator.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module haar_stage_evaluator (
	input wire clk_fpga,
	input wire arst_n,
	input wire start,
	input wire haar_pkg::haar_word_u [`HAAR_NUM_CLASSIFIERS*`HAAR_NUM_SLOTS-1:0] param_bank,
	input wire haar_pkg::haar_word_u stage_threshold,
	output logic [`HAAR_INDEX_W-1:0] corner_addr_a,
	output logic [`HAAR_INDEX_W-1:0] corner_addr_b,
	output logic [`HAAR_INDEX_W-1:0] corner_addr_c,
	output logic [`HAAR_INDEX_W-1:0] corner_addr_d,
	input wire [`HAAR_WORD_W-1:0] corner_a,
	input wire [`HAAR_WORD_W-1:0] corner_b,
	input wire [`HAAR_WORD_W-1:0] corner_c,
	input wire [`HAAR_WORD_W-1:0] corner_d,
	output logic busy,
	output logic done,
	output logic candidate,
	output logic signed [`HAAR_STAGE_W-1:0] stage_sum
);

	localparam int SW = `HAAR_STAGE_W;
	localparam int CLS_W = $clog2(`HAAR_NUM_CLASSIFIERS + 1);
	localparam int BANK_AW = $clog2(`HAAR_NUM_CLASSIFIERS * `HAAR_NUM_SLOTS);

	logic [CLS_W-1:0] cls_cnt;
	logic [1:0] rect_cnt;
	logic rect_active;
	logic rect_first;
	logic rect_last;
	logic cls_last;
	haar_pkg::haar_slot_e slot_a;
	haar_pkg::haar_slot_e slot_b;
	haar_pkg::haar_slot_e slot_c;
	haar_pkg::haar_slot_e slot_d;
	haar_pkg::haar_slot_e slot_w;
	haar_pkg::haar_word_u weight_word;
	haar_pkg::haar_word_u thr_word;
	haar_pkg::haar_word_u left_word;
	haar_pkg::haar_word_u right_word;
	logic vote_valid;
	logic signed [`HAAR_WORD_W-1:0] vote;
	logic signed [SW-1:0] vote_acc;
	logic signed [SW-1:0] vote_total;
	logic signed [SW-1:0] stage_thr_ext;

	function automatic haar_pkg::haar_word_u bank_word(input logic [CLS_W-1:0] cls,
		input haar_pkg::haar_slot_e slot);
		logic [BANK_AW-1:0] idx;
		idx = BANK_AW'(cls * `HAAR_NUM_SLOTS + slot);
		return param_bank[idx];
	endfunction

	// corner slot read through its index view
	function automatic logic [`HAAR_INDEX_W-1:0] bank_index(input logic [CLS_W-1:0] cls,
		input haar_pkg::haar_slot_e slot);
		haar_pkg::haar_word_u bank_entry;
		bank_entry = bank_word(cls, slot);
		return bank_entry.idx.index;
	endfunction

	// slots of the rectangle currently presented
	always_comb
	begin
		case (rect_cnt)
			2'd1:
			begin
				slot_a = haar_pkg::slot_rect2_a;
				slot_b = haar_pkg::slot_rect2_b;
				slot_c = haar_pkg::slot_rect2_c;
				slot_d = haar_pkg::slot_rect2_d;
				slot_w = haar_pkg::slot_weight2;
			end
			2'd2:
			begin
				slot_a = haar_pkg::slot_rect3_a;
				slot_b = haar_pkg::slot_rect3_b;
				slot_c = haar_pkg::slot_rect3_c;
				slot_d = haar_pkg::slot_rect3_d;
				slot_w = haar_pkg::slot_weight3;
			end
			default:
			begin
				slot_a = haar_pkg::slot_rect1_a;
				slot_b = haar_pkg::slot_rect1_b;
				slot_c = haar_pkg::slot_rect1_c;
				slot_d = haar_pkg::slot_rect1_d;
				slot_w = haar_pkg::slot_weight1;
			end
		endcase
	end

	always_comb
	begin
		corner_addr_a = bank_index(cls_cnt, slot_a);
		corner_addr_b = bank_index(cls_cnt, slot_b);
		corner_addr_c = bank_index(cls_cnt, slot_c);
		corner_addr_d = bank_index(cls_cnt, slot_d);
		weight_word = bank_word(cls_cnt, slot_w);
		thr_word = bank_word(cls_cnt, haar_pkg::slot_threshold);
		left_word = bank_word(cls_cnt, haar_pkg::slot_left);
		right_word = bank_word(cls_cnt, haar_pkg::slot_right);
	end

	assign rect_first = (rect_cnt == 2'd0);
	assign rect_last = (rect_cnt == 2'd2);
	assign cls_last = (cls_cnt == CLS_W'(`HAAR_NUM_CLASSIFIERS - 1));

	haar_feature_mac u_mac (
		.clk_fpga(clk_fpga),
		.arst_n(arst_n),
		.rect_valid(rect_active),
		.rect_first(rect_first),
		.rect_last(rect_last),
		.corner_a(corner_a),
		.corner_b(corner_b),
		.corner_c(corner_c),
		.corner_d(corner_d),
		.weight(weight_word),
		.threshold(thr_word),
		.left_vote(left_word),
		.right_vote(right_word),
		.vote_valid(vote_valid),
		.vote(vote)
	);

	assign vote_total = vote_acc + SW'(vote);
	assign stage_thr_ext = SW'(stage_threshold.value);

	always_ff @(posedge clk_fpga or negedge arst_n)
	begin
		if (!arst_n)
		begin
			busy <= 1'b0;
			done <= 1'b0;
			candidate <= 1'b0;
			stage_sum <= '0;
			rect_active <= 1'b0;
			cls_cnt <= '0;
			rect_cnt <= '0;
			vote_acc <= '0;
		end
		else
		begin
			done <= 1'b0;
			if (!busy)
			begin
				if (start)
				begin
					busy <= 1'b1;
					rect_active <= 1'b1;
					cls_cnt <= '0;
					rect_cnt <= '0;
					vote_acc <= '0;
				end
			end
			else
			begin
				if (rect_active)
				begin
					if (rect_last)
					begin
						rect_cnt <= '0;
						if (cls_last)
						begin
							rect_active <= 1'b0;
						end
						else
						begin
							cls_cnt <= cls_cnt + 1'b1;
						end
					end
					else
					begin
						rect_cnt <= rect_cnt + 2'd1;
					end
				end
				// last vote lands after the walk has stopped
				if (vote_valid)
				begin
					if (rect_active)
					begin
						vote_acc <= vote_total;
					end
					else
					begin
						stage_sum <= vote_total;
						candidate <= (vote_total > stage_thr_ext);
						done <= 1'b1;
						busy <= 1'b0;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

//--- source/haar_stage_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module haar_stage_top (
	input wire clk_fpga,
	input wire arst_n,
	input wire win_we,
	input wire [`HAAR_INDEX_W-1:0] win_addr,
	input wire [`HAAR_WORD_W-1:0] win_data,
	input wire load_en,
	input wire [7:0] load_classifier,
	input wire [7:0] load_slot,
	input wire [`HAAR_WORD_W-1:0] load_data,
	input wire start,
	output wire busy,
	output wire done,
	output wire candidate,
	output wire signed [`HAAR_STAGE_W-1:0] stage_sum
);

	wire haar_pkg::haar_word_u [`HAAR_NUM_CLASSIFIERS*`HAAR_NUM_SLOTS-1:0] param_bank;
	wire haar_pkg::haar_word_u stage_threshold;
	wire [`HAAR_INDEX_W-1:0] corner_addr_a;
	wire [`HAAR_INDEX_W-1:0] corner_addr_b;
	wire [`HAAR_INDEX_W-1:0] corner_addr_c;
	wire [`HAAR_INDEX_W-1:0] corner_addr_d;
	wire [`HAAR_WORD_W-1:0] corner_a;
	wire [`HAAR_WORD_W-1:0] corner_b;
	wire [`HAAR_WORD_W-1:0] corner_c;
	wire [`HAAR_WORD_W-1:0] corner_d;

	haar_param_loader u_loader (
		.clk_fpga(clk_fpga),
		.arst_n(arst_n),
		.load_en(load_en),
		.load_classifier(load_classifier),
		.load_slot(load_slot),
		.load_data(load_data),
		.param_bank(param_bank),
		.stage_threshold(stage_threshold)
	);

	integral_window_buffer u_window (
		.clk_fpga(clk_fpga),
		.win_we(win_we),
		.win_addr(win_addr),
		.win_data(win_data),
		.corner_addr_a(corner_addr_a),
		.corner_addr_b(corner_addr_b),
		.corner_addr_c(corner_addr_c),
		.corner_addr_d(corner_addr_d),
		.corner_a(corner_a),
		.corner_b(corner_b),
		.corner_c(corner_c),
		.corner_d(corner_d)
	);

	haar_stage_evaluator u_evaluator (
		.clk_fpga(clk_fpga),
		.arst_n(arst_n),
		.start(start),
		.param_bank(param_bank),
		.stage_threshold(stage_threshold),
		.corner_addr_a(corner_addr_a),
		.corner_addr_b(corner_addr_b),
		.corner_addr_c(corner_addr_c),
		.corner_addr_d(corner_addr_d),
		.corner_a(corner_a),
		.corner_b(corner_b),
		.corner_c(corner_c),
		.corner_d(corner_d),
		.busy(busy),
		.done(done),
		.candidate(candidate),
		.stage_sum(stage_sum)
	);

endmodule

`default_nettype wire

//--- verif/tb_clock_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
	parameter real PERIOD_NS = 20.0
) (
	output logic clk_fpga
);

	initial
	begin
		clk_fpga = 1'b0;
	end

	always
	begin
		#(PERIOD_NS / 2.0) clk_fpga = ~clk_fpga;
	end

endmodule

`default_nettype wire

//--- verif/haar_stage_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "haar_defines.svh"

module haar_stage_tb;

	localparam int N = `HAAR_NUM_CLASSIFIERS;
	localparam int SLOTS = `HAAR_NUM_SLOTS;
	localparam int NUM_ROWS = 9;
	localparam int LOAD_CYCLES = `HAAR_WINDOW_DEPTH + N * SLOTS + 16;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * (3 * N + 50) + NUM_ROWS * LOAD_CYCLES + 64;

	typedef struct {
		string name;
		bit rand_win;
		bit rand_par;
		logic [15:0] weight;
		logic [15:0] cls_thr;
		logic [15:0] left;
		logic [15:0] right;
		logic [15:0] stage_thr;
		int extra;
	} row_t;

	wire clk_fpga;
	logic arst_n;
	logic win_we;
	logic [7:0] win_addr;
	logic [15:0] win_data;
	logic load_en;
	logic [7:0] load_classifier;
	logic [7:0] load_slot;
	logic [15:0] load_data;
	logic start;
	wire busy;
	wire done;
	wire candidate;
	wire signed [`HAAR_STAGE_W-1:0] stage_sum;

	logic [15:0] win_model [0:`HAAR_WINDOW_DEPTH-1];
	logic [15:0] param_model [0:N*SLOTS-1];
	logic [15:0] stage_thr_model;
	logic [31:0] lcg_state;
	row_t table_q [$];

	tb_clock_gen u_clk (
		.clk_fpga(clk_fpga)
	);

	haar_stage_top uut (
		.clk_fpga(clk_fpga),
		.arst_n(arst_n),
		.win_we(win_we),
		.win_addr(win_addr),
		.win_data(win_data),
		.load_en(load_en),
		.load_classifier(load_classifier),
		.load_slot(load_slot),
		.load_data(load_data),
		.start(start),
		.busy(busy),
		.done(done),
		.candidate(candidate),
		.stage_sum(stage_sum)
	);

	function automatic logic [15:0] lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15];
	endfunction

	// feature of one classifier, wraps at 32 bits
	function automatic int model_feature(input int c);
		int feature;
		int corner_sum;
		int weight;
		int base;
		feature = 0;
		for (int r = 0; r < 3; r++)
		begin
			base = c * SLOTS + r * 5;
			corner_sum = int'(win_model[param_model[base][7:0]])
				- int'(win_model[param_model[base + 1][7:0]])
				- int'(win_model[param_model[base + 2][7:0]])
				+ int'(win_model[param_model[base + 3][7:0]]);
			weight = int'($signed(param_model[base + 4]));
			feature = feature + corner_sum * weight;
		end
		return feature;
	endfunction

	// votes are sign-extended into the stage sum
	function automatic logic signed [`HAAR_STAGE_W-1:0] model_stage_sum();
		logic signed [`HAAR_STAGE_W-1:0] sum;
		int thr;
		logic [15:0] vote;
		sum = '0;
		for (int c = 0; c < N; c++)
		begin
			thr = int'($signed(param_model[c * SLOTS + 15]));
			vote = (model_feature(c) < thr) ? param_model[c * SLOTS + 16]
				: param_model[c * SLOTS + 17];
			sum = sum + {{4{vote[15]}}, vote};
		end
		return sum;
	endfunction

	task automatic check_value(input string test_name, input longint expected,
		input longint actual);
		if (expected != actual)
		begin
			$display("Error %s expected %0d actual %0d", test_name, expected, actual);
			$display("Test failed");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	task automatic add_row(input string name, input bit rand_win, input bit rand_par,
		input int weight, input int cls_thr, input int left, input int right,
		input int stage_thr, input int extra);
		row_t row;
		row.name = name;
		row.rand_win = rand_win;
		row.rand_par = rand_par;
		row.weight = 16'(weight);
		row.cls_thr = 16'(cls_thr);
		row.left = 16'(left);
		row.right = 16'(right);
		row.stage_thr = 16'(stage_thr);
		row.extra = extra;
		table_q.push_back(row);
	endtask

	task automatic write_window(input int addr, input logic [15:0] data);
		@(posedge clk_fpga);
		load_en <= 1'b0;
		win_we <= 1'b1;
		win_addr <= 8'(addr);
		win_data <= data;
	endtask

	task automatic load_param(input int cls, input int slot, input logic [15:0] data);
		@(posedge clk_fpga);
		win_we <= 1'b0;
		load_en <= 1'b1;
		load_classifier <= 8'(cls);
		load_slot <= 8'(slot);
		load_data <= data;
	endtask

	task automatic release_strobes();
		@(posedge clk_fpga);
		win_we <= 1'b0;
		load_en <= 1'b0;
	endtask

	task automatic prepare_row(input row_t row);
		for (int i = 0; i < `HAAR_WINDOW_DEPTH; i++)
		begin
			if (row.rand_win)
			begin
				win_model[i] = lcg_next();
			end
			else
			begin
				win_model[i] = 16'(i * 4 + 1);
			end
		end
		for (int i = 0; i < N * SLOTS; i++)
		begin
			param_model[i] = row.rand_par ? lcg_next() : 16'h0000;
		end
		stage_thr_model = row.rand_par ? lcg_next() : row.stage_thr;
		// fixed rows use one rectangle of classifier 0, corners 10 20 40 90
		if (!row.rand_par)
		begin
			param_model[0] = 16'd10;
			param_model[1] = 16'd20;
			param_model[2] = 16'd40;
			param_model[3] = 16'd90;
			param_model[4] = row.weight;
			param_model[15] = row.cls_thr;
			param_model[16] = row.left;
			param_model[17] = row.right;
		end
		for (int i = 0; i < `HAAR_WINDOW_DEPTH; i++)
		begin
			write_window(i, win_model[i]);
		end
		for (int i = 0; i < N * SLOTS; i++)
		begin
			load_param(i / SLOTS, i % SLOTS, param_model[i]);
		end
		load_param(N, 0, stage_thr_model);
		release_strobes();
	endtask

	task automatic run_and_check(input row_t row, input string tag);
		string test_name;
		logic signed [`HAAR_STAGE_W-1:0] exp_sum;
		logic exp_cand;
		int edges;
		int extra_done;
		test_name = {row.name, tag};
		exp_sum = model_stage_sum();
		exp_cand = exp_sum > $signed({{4{stage_thr_model[15]}}, stage_thr_model});
		@(posedge clk_fpga);
		start <= 1'b1;
		@(posedge clk_fpga);
		start <= 1'b0;
		@(negedge clk_fpga);
		check_value({test_name, " busy"}, longint'(1), longint'(busy));
		edges = 0;
		extra_done = 0;
		do
		begin
			@(posedge clk_fpga);
			edges++;
			// restart row pokes start again while the walk is running
			if (row.extra == 1 && edges == 2)
			begin
				start <= 1'b1;
			end
			else
			begin
				start <= 1'b0;
			end
			@(negedge clk_fpga);
		end
		while (!done);
		check_value({test_name, " latency"}, longint'(3 * N + 1), longint'(edges));
		check_value({test_name, " busy at done"}, longint'(0), longint'(busy));
		check_value({test_name, " stage_sum"}, longint'(exp_sum), longint'(stage_sum));
		check_value({test_name, " candidate"}, longint'(exp_cand), longint'(candidate));
		if (row.extra == 1)
		begin
			repeat (3 * N + 4)
			begin
				@(negedge clk_fpga);
				if (done)
				begin
					extra_done++;
				end
			end
			check_value({test_name, " extra done"}, longint'(0), longint'(extra_done));
			check_value({test_name, " stage_sum held"}, longint'(exp_sum), longint'(stage_sum));
		end
	endtask

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk_fpga);
		$display("Timeout: the DUT did not finish all tests in the allowed cycles");
		$display("Test failed");
		$fatal(1, "watchdog expired");
	end

	initial
	begin
		int vote_slot;
		arst_n = 1'b0;
		win_we = 1'b0;
		win_addr = '0;
		win_data = '0;
		load_en = 1'b0;
		load_classifier = '0;
		load_slot = '0;
		load_data = '0;
		start = 1'b0;
		lcg_state = 32'd22;

		// name, rand window, rand params, weight, cls thr, left, right, stage thr, extra
		// ramp window gives feature -480 for weight -3
		add_row("left_vote", 0, 0, -3, -479, 7, -5, 6, 0);
		add_row("thr_equal", 0, 0, -3, -480, 7, -5, 0, 0);
		add_row("thr_below", 0, 0, -3, -481, 7, -5, -6, 0);
		add_row("stage_equal", 0, 0, -3, -479, 7, -5, 7, 0);
		add_row("stage_above", 0, 0, -3, -479, 7, -5, 8, 0);
		add_row("restart_busy", 0, 0, -3, -479, 7, -5, 6, 1);
		add_row("random_a", 1, 1, 0, 0, 0, 0, 0, 0);
		add_row("random_b", 1, 1, 0, 0, 0, 0, 0, 0);
		add_row("reload_slot", 1, 1, 0, 0, 0, 0, 0, 2);

		repeat (10) @(posedge clk_fpga);
		arst_n <= 1'b1;
		@(negedge clk_fpga);
		check_value("reset busy", longint'(0), longint'(busy));
		check_value("reset done", longint'(0), longint'(done));
		check_value("reset candidate", longint'(0), longint'(candidate));
		check_value("reset stage_sum", longint'(0), longint'(stage_sum));

		foreach (table_q[i])
		begin
			prepare_row(table_q[i]);
			run_and_check(table_q[i], "");
			if (table_q[i].extra == 2)
			begin
				// invert the vote word classifier 0 picks, then three loads to be ignored
				vote_slot = (model_feature(0) < int'($signed(param_model[15]))) ? 16 : 17;
				load_param(0, vote_slot, ~param_model[vote_slot]);
				load_param(1, SLOTS, 16'h7777);
				load_param(N, 1, 16'h7777);
				load_param(N + 1, 0, 16'h7777);
				release_strobes();
				param_model[vote_slot] = ~param_model[vote_slot];
				run_and_check(table_q[i], " reload");
			end
		end

		$display("Test passed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/haar_pkg.sv
source/haar_param_loader.sv
source/integral_window_buffer.sv
source/haar_feature_mac.sv
source/haar_stage_evaluator.sv
source/haar_stage_top.sv
verif/tb_clock_gen.sv
verif/haar_stage_tb.sv

//--- Makefile
# Verilator build and run for the Haar stage testbench

SIM = obj_dir/haar_stage_sim

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -f build.f --top-module haar_stage_tb \
		-Mdir obj_dir -o haar_stage_sim

run: compile
	./$(SIM) | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log
